// File: rv32_isa_pkg.sv
`default_nettype none

package rv32_isa_pkg;

   localparam int XLEN_INSTR = 32;

   typedef logic [XLEN_INSTR-1:0] rv32_instr_t;
   typedef logic [4:0]            rv_reg_t;

   ////////////////////
   // major opcodes
   ////////////////////
   localparam logic [6:0] OPC_LOAD   = 7'h03;
   localparam logic [6:0] OPC_OP_IMM = 7'h13;
   localparam logic [6:0] OPC_STORE  = 7'h23;
   localparam logic [6:0] OPC_OP     = 7'h33;
   localparam logic [6:0] OPC_LUI    = 7'h37;
   localparam logic [6:0] OPC_BRANCH = 7'h63;
   localparam logic [6:0] OPC_JALR   = 7'h67;
   localparam logic [6:0] OPC_JAL    = 7'h6f;

   ////////////////////
   // funct3 / funct7
   ////////////////////
   localparam logic [2:0] F3_ADD   = 3'b000;   // also jalr
   localparam logic [2:0] F3_SLL   = 3'b001;
   localparam logic [2:0] F3_SR    = 3'b101;   // srl and sra
   localparam logic [2:0] F3_XOR   = 3'b100;
   localparam logic [2:0] F3_OR    = 3'b110;
   localparam logic [2:0] F3_AND   = 3'b111;
   localparam logic [2:0] F3_LW_SW = 3'b010;
   localparam logic [2:0] F3_BEQ   = 3'b000;
   localparam logic [2:0] F3_BNE   = 3'b001;

   localparam logic [6:0] F7_BASE    = 7'b0000000;
   localparam logic [6:0] F7_SUB_SRA = 7'b0100000;

   ////////////////////
   // fixed registers
   ////////////////////
   localparam rv_reg_t REG_ZERO = 5'd0;
   localparam rv_reg_t REG_RA   = 5'd1;   // link register
   localparam rv_reg_t REG_SP   = 5'd2;

   // all-zero word is the architecturally defined illegal instruction
   localparam rv32_instr_t RVC_ILLEGAL_EXP = '0;

endpackage

`default_nettype wire

// File: rvc_pkg.sv
`default_nettype none

package rvc_pkg;

   typedef logic [1:0] c_quadrant_t;

   localparam c_quadrant_t Q0 = 2'b00;
   localparam c_quadrant_t Q1 = 2'b01;
   localparam c_quadrant_t Q2 = 2'b10;

   ////////////////////
   // compressed formats
   ////////////////////
   typedef struct packed {
      logic [3:0]  funct4;
      logic [4:0]  rd_rs1;
      logic [4:0]  rs2;
      c_quadrant_t op;
   } rvc_cr_t;

   typedef struct packed {
      logic [2:0]  funct3;
      logic        imm_hi;    // bit 12
      logic [4:0]  rd_rs1;
      logic [4:0]  imm_lo;    // bits 6:2
      c_quadrant_t op;
   } rvc_ci_t;

   typedef struct packed {
      logic [2:0]  funct3;
      logic [5:0]  imm;       // bits 12:7
      logic [4:0]  rs2;
      c_quadrant_t op;
   } rvc_css_t;

   typedef struct packed {
      logic [2:0]  funct3;
      logic [7:0]  imm;       // bits 12:5
      logic [2:0]  rd_p;
      c_quadrant_t op;
   } rvc_ciw_t;

   typedef struct packed {
      logic [2:0]  funct3;
      logic [2:0]  imm_hi;    // bits 12:10
      logic [2:0]  rs1_p;
      logic [1:0]  imm_lo;    // bits 6:5
      logic [2:0]  rd_p;
      c_quadrant_t op;
   } rvc_cl_t;

   typedef struct packed {
      logic [2:0]  funct3;
      logic [2:0]  imm_hi;
      logic [2:0]  rs1_p;
      logic [1:0]  imm_lo;
      logic [2:0]  rs2_p;
      c_quadrant_t op;
   } rvc_cs_t;

   typedef struct packed {
      logic [2:0]  funct3;
      logic [2:0]  off_hi;    // bits 12:10
      logic [2:0]  rs1_p;
      logic [4:0]  off_lo;    // bits 6:2
      c_quadrant_t op;
   } rvc_cb_t;

   typedef struct packed {
      logic [2:0]  funct3;
      logic [10:0] target;    // bits 12:2, scrambled offset
      c_quadrant_t op;
   } rvc_cj_t;

   typedef union packed {
      rvc_cr_t  cr;
      rvc_ci_t  ci;
      rvc_css_t css;
      rvc_ciw_t ciw;
      rvc_cl_t  cl;
      rvc_cs_t  cs;
      rvc_cb_t  cb;
      rvc_cj_t  cj;
   } rvc_word_u;

   ////////////////////
   // funct codes
   ////////////////////
   localparam logic [2:0] CF3_ADDI4SPN = 3'b000;   // quadrant 0
   localparam logic [2:0] CF3_LW       = 3'b010;
   localparam logic [2:0] CF3_SW       = 3'b110;

   localparam logic [2:0] CF3_ADDI     = 3'b000;   // quadrant 1
   localparam logic [2:0] CF3_LI       = 3'b010;
   localparam logic [2:0] CF3_LUI_SP   = 3'b011;   // lui or addi16sp
   localparam logic [2:0] CF3_ALU      = 3'b100;
   localparam logic [2:0] CF3_J        = 3'b101;
   localparam logic [2:0] CF3_BEQZ     = 3'b110;
   localparam logic [2:0] CF3_BNEZ     = 3'b111;

   localparam logic [2:0] CF3_SLLI     = 3'b000;   // quadrant 2
   localparam logic [2:0] CF3_LWSP     = 3'b010;
   localparam logic [2:0] CF3_JR_ADD   = 3'b100;
   localparam logic [2:0] CF3_SWSP     = 3'b110;

   // quadrant 1 arithmetic group, bits 11:10 then bits 6:5
   localparam logic [1:0] CF2_SRLI = 2'b00;
   localparam logic [1:0] CF2_SRAI = 2'b01;
   localparam logic [1:0] CF2_ANDI = 2'b10;
   localparam logic [1:0] CF2_REG  = 2'b11;
   localparam logic [1:0] CA_SUB   = 2'b00;
   localparam logic [1:0] CA_XOR   = 2'b01;
   localparam logic [1:0] CA_OR    = 2'b10;
   localparam logic [1:0] CA_AND   = 2'b11;

   localparam logic [1:0] CREG_BASE = 2'b01;   // x8..x15

endpackage

`default_nettype wire

// File: rvc_expand_if.sv
`default_nettype none
`timescale 1ns/1ns

interface rvc_expand_if import rv32_isa_pkg::*; ();

   rv32_instr_t q0_exp;
   rv32_instr_t q1_exp;
   rv32_instr_t q2_exp;
   logic        q0_legal;
   logic        q1_legal;
   logic        q2_legal;

   modport exp_q0 (output q0_exp, output q0_legal);
   modport exp_q1 (output q1_exp, output q1_legal);
   modport exp_q2 (output q2_exp, output q2_legal);

   modport sel (
      input q0_exp,
      input q1_exp,
      input q2_exp,
      input q0_legal,
      input q1_legal,
      input q2_legal
   );

endinterface

`default_nettype wire

// File: rvc_expand_q0.sv
`default_nettype none
`timescale 1ns/1ns

module rvc_expand_q0 import rv32_isa_pkg::*; import rvc_pkg::*; (
   input  rvc_word_u          rvc_word_i,
   rvc_expand_if.exp_q0       exp
);

   logic [11:0] imm_4spn;
   logic [11:0] off_lsw;
   rv_reg_t     rd_p;
   rv_reg_t     rs1_p;
   rv_reg_t     rs2_p;

   // nzuimm[5:4|9:6|2|3]
   assign imm_4spn = {2'b00, rvc_word_i.ciw.imm[5:2], rvc_word_i.ciw.imm[7:6],
                      rvc_word_i.ciw.imm[0], rvc_word_i.ciw.imm[1], 2'b00};

   // uimm[5:3] at 12:10, uimm[2|6] at 6:5
   assign off_lsw = {5'b00000, rvc_word_i.cl.imm_lo[0], rvc_word_i.cl.imm_hi,
                     rvc_word_i.cl.imm_lo[1], 2'b00};

   assign rd_p  = {CREG_BASE, rvc_word_i.ciw.rd_p};
   assign rs1_p = {CREG_BASE, rvc_word_i.cl.rs1_p};
   assign rs2_p = {CREG_BASE, rvc_word_i.cs.rs2_p};

   always_comb begin
      exp.q0_exp   = RVC_ILLEGAL_EXP;
      exp.q0_legal = 1'b0;
      case (rvc_word_i.ciw.funct3)
         CF3_ADDI4SPN: begin
            if (rvc_word_i.ciw.imm != '0) begin   // zero imm is reserved
               exp.q0_exp   = {imm_4spn, REG_SP, F3_ADD, rd_p, OPC_OP_IMM};
               exp.q0_legal = 1'b1;
            end
         end
         CF3_LW: begin
            exp.q0_exp   = {off_lsw, rs1_p, F3_LW_SW, {CREG_BASE, rvc_word_i.cl.rd_p}, OPC_LOAD};
            exp.q0_legal = 1'b1;
         end
         CF3_SW: begin
            exp.q0_exp   = {off_lsw[11:5], rs2_p, rs1_p, F3_LW_SW, off_lsw[4:0], OPC_STORE};
            exp.q0_legal = 1'b1;
         end
         default: ;   // ld/sd and reserved rows
      endcase
   end

endmodule

`default_nettype wire

// File: rvc_expand_q1.sv
`default_nettype none
`timescale 1ns/1ns

module rvc_expand_q1 import rv32_isa_pkg::*; import rvc_pkg::*; (
   input  rvc_word_u          rvc_word_i,
   rvc_expand_if.exp_q1       exp
);

   logic [11:0] imm_ci;
   logic [11:0] imm_16sp;
   logic [19:0] imm_lui;
   logic [11:1] off_j;
   logic [8:1]  off_b;
   logic [2:0]  f3_b;
   rv_reg_t     rd;
   rv_reg_t     rd_p;
   rv_reg_t     rs2_p;

   ////////////////////
   // immediates
   ////////////////////
   assign imm_ci = {{6{rvc_word_i.ci.imm_hi}}, rvc_word_i.ci.imm_hi, rvc_word_i.ci.imm_lo};

   // nzimm[9|4|6|8:7|5], scaled by 16
   assign imm_16sp = {{3{rvc_word_i.ci.imm_hi}}, rvc_word_i.ci.imm_lo[2:1],
                      rvc_word_i.ci.imm_lo[3], rvc_word_i.ci.imm_lo[0],
                      rvc_word_i.ci.imm_lo[4], 4'b0000};

   assign imm_lui = {{14{rvc_word_i.ci.imm_hi}}, rvc_word_i.ci.imm_hi, rvc_word_i.ci.imm_lo};

   // offset[11|4|9:8|10|6|7|3:1|5]
   assign off_j = {rvc_word_i.cj.target[10], rvc_word_i.cj.target[6],
                   rvc_word_i.cj.target[8:7], rvc_word_i.cj.target[4],
                   rvc_word_i.cj.target[5], rvc_word_i.cj.target[0],
                   rvc_word_i.cj.target[9], rvc_word_i.cj.target[3:1]};

   // offset[8|4:3] and [7:6|2:1|5]
   assign off_b = {rvc_word_i.cb.off_hi[2], rvc_word_i.cb.off_lo[4:3],
                   rvc_word_i.cb.off_lo[0], rvc_word_i.cb.off_hi[1:0],
                   rvc_word_i.cb.off_lo[2:1]};

   assign f3_b  = (rvc_word_i.cb.funct3 == CF3_BNEZ) ? F3_BNE : F3_BEQ;

   assign rd    = rvc_word_i.ci.rd_rs1;
   assign rd_p  = {CREG_BASE, rvc_word_i.cb.rs1_p};
   assign rs2_p = {CREG_BASE, rvc_word_i.cs.rs2_p};

   always_comb begin
      exp.q1_exp   = RVC_ILLEGAL_EXP;
      exp.q1_legal = 1'b0;
      case (rvc_word_i.ci.funct3)
         CF3_ADDI: begin   // c.nop is addi x0, x0, 0
            exp.q1_exp   = {imm_ci, rd, F3_ADD, rd, OPC_OP_IMM};
            exp.q1_legal = 1'b1;
         end
         CF3_LI: begin
            exp.q1_exp   = {imm_ci, REG_ZERO, F3_ADD, rd, OPC_OP_IMM};
            exp.q1_legal = 1'b1;
         end
         CF3_LUI_SP: begin
            if ({rvc_word_i.ci.imm_hi, rvc_word_i.ci.imm_lo} != '0) begin
               exp.q1_legal = 1'b1;
               if (rd == REG_SP) begin
                  exp.q1_exp = {imm_16sp, REG_SP, F3_ADD, REG_SP, OPC_OP_IMM};
               end else begin
                  exp.q1_exp = {imm_lui, rd, OPC_LUI};
               end
            end
         end
         CF3_ALU: begin
            case (rvc_word_i.cb.off_hi[1:0])
               CF2_SRLI: begin
                  if (!rvc_word_i.cb.off_hi[2]) begin   // shamt[5] set is rv64 only
                     exp.q1_exp   = {F7_BASE, rvc_word_i.cb.off_lo, rd_p, F3_SR, rd_p, OPC_OP_IMM};
                     exp.q1_legal = 1'b1;
                  end
               end
               CF2_SRAI: begin
                  if (!rvc_word_i.cb.off_hi[2]) begin
                     exp.q1_exp   = {F7_SUB_SRA, rvc_word_i.cb.off_lo, rd_p, F3_SR, rd_p,
                                     OPC_OP_IMM};
                     exp.q1_legal = 1'b1;
                  end
               end
               CF2_ANDI: begin
                  exp.q1_exp   = {imm_ci, rd_p, F3_AND, rd_p, OPC_OP_IMM};
                  exp.q1_legal = 1'b1;
               end
               CF2_REG: begin
                  if (!rvc_word_i.cs.imm_hi[2]) begin   // bit 12 set is subw/addw
                     exp.q1_legal = 1'b1;
                     case (rvc_word_i.cs.imm_lo)
                        CA_SUB: exp.q1_exp = {F7_SUB_SRA, rs2_p, rd_p, F3_ADD, rd_p, OPC_OP};
                        CA_XOR: exp.q1_exp = {F7_BASE, rs2_p, rd_p, F3_XOR, rd_p, OPC_OP};
                        CA_OR:  exp.q1_exp = {F7_BASE, rs2_p, rd_p, F3_OR, rd_p, OPC_OP};
                        CA_AND: exp.q1_exp = {F7_BASE, rs2_p, rd_p, F3_AND, rd_p, OPC_OP};
                     endcase
                  end
               end
            endcase
         end
         CF3_J: begin
            exp.q1_exp   = {off_j[11], off_j[10:1], off_j[11], {8{off_j[11]}},
                            REG_ZERO, OPC_JAL};
            exp.q1_legal = 1'b1;
         end
         CF3_BEQZ, CF3_BNEZ: begin
            exp.q1_exp   = {off_b[8], {2{off_b[8]}}, off_b[8:5], REG_ZERO, rd_p, f3_b,
                            off_b[4:1], off_b[8], OPC_BRANCH};
            exp.q1_legal = 1'b1;
         end
         default: ;   // addiw row
      endcase
   end

endmodule

`default_nettype wire

// File: rvc_expand_q2.sv
`default_nettype none
`timescale 1ns/1ns

module rvc_expand_q2 import rv32_isa_pkg::*; import rvc_pkg::*; (
   input  rvc_word_u          rvc_word_i,
   rvc_expand_if.exp_q2       exp
);

   logic [11:0] off_lwsp;
   logic [11:0] off_swsp;
   rv_reg_t     rd;
   rv_reg_t     rs2;
   rv_reg_t     link_rd;
   rv_reg_t     add_rs1;

   // uimm[5] at 12, uimm[4:2|7:6] at 6:2
   assign off_lwsp = {4'b0000, rvc_word_i.ci.imm_lo[1:0], rvc_word_i.ci.imm_hi,
                      rvc_word_i.ci.imm_lo[4:2], 2'b00};

   // uimm[5:2|7:6] at 12:7
   assign off_swsp = {4'b0000, rvc_word_i.css.imm[1:0], rvc_word_i.css.imm[5:2], 2'b00};

   assign rd  = rvc_word_i.cr.rd_rs1;
   assign rs2 = rvc_word_i.cr.rs2;

   // bit 12 turns jr into jalr and mv into add
   assign link_rd = rvc_word_i.cr.funct4[0] ? REG_RA : REG_ZERO;
   assign add_rs1 = rvc_word_i.cr.funct4[0] ? rd : REG_ZERO;

   always_comb begin
      exp.q2_exp   = RVC_ILLEGAL_EXP;
      exp.q2_legal = 1'b0;
      case (rvc_word_i.ci.funct3)
         CF3_SLLI: begin
            if (!rvc_word_i.ci.imm_hi) begin   // shamt[5] is rv64 only
               exp.q2_exp   = {F7_BASE, rvc_word_i.ci.imm_lo, rd, F3_SLL, rd, OPC_OP_IMM};
               exp.q2_legal = 1'b1;
            end
         end
         CF3_LWSP: begin
            if (rd != REG_ZERO) begin
               exp.q2_exp   = {off_lwsp, REG_SP, F3_LW_SW, rd, OPC_LOAD};
               exp.q2_legal = 1'b1;
            end
         end
         CF3_JR_ADD: begin
            if (rs2 == REG_ZERO) begin
               if (rd != REG_ZERO) begin   // rs1 = x0 is reserved or ebreak
                  exp.q2_exp   = {12'h000, rd, F3_ADD, link_rd, OPC_JALR};
                  exp.q2_legal = 1'b1;
               end
            end else begin
               exp.q2_exp   = {F7_BASE, rs2, add_rs1, F3_ADD, rd, OPC_OP};
               exp.q2_legal = 1'b1;
            end
         end
         CF3_SWSP: begin
            exp.q2_exp   = {off_swsp[11:5], rvc_word_i.css.rs2, REG_SP, F3_LW_SW,
                            off_swsp[4:0], OPC_STORE};
            exp.q2_legal = 1'b1;
         end
         default: ;   // ldsp, sdsp, fp rows
      endcase
   end

endmodule

`default_nettype wire

// File: rvc_output_stage.sv
`default_nettype none
`timescale 1ns/1ns

module rvc_output_stage import rv32_isa_pkg::*; import rvc_pkg::*; (
   input  logic          clk_i,
   input  logic          rstn_i,
   input  logic          instr_ready_i,
   input  logic          is_compressed_i,
   input  c_quadrant_t   quadrant_i,
   input  rv32_instr_t   instr_i,
   rvc_expand_if.sel     exp,
   output rv32_instr_t   instr_decompressed_o,
   output logic          instr_decompressed_ready_o
);

   rv32_instr_t instr_sel;

   ////////////////////
   // result select
   ////////////////////
   always_comb begin
      instr_sel = instr_i;   // full-width word passes through
      if (is_compressed_i) begin
         case (quadrant_i)
            Q0:      instr_sel = exp.q0_legal ? exp.q0_exp : RVC_ILLEGAL_EXP;
            Q1:      instr_sel = exp.q1_legal ? exp.q1_exp : RVC_ILLEGAL_EXP;
            Q2:      instr_sel = exp.q2_legal ? exp.q2_exp : RVC_ILLEGAL_EXP;
            default: instr_sel = RVC_ILLEGAL_EXP;   // 11 is not a compressed quadrant
         endcase
      end
   end

   ////////////////////
   // output register
   ////////////////////
   always_ff @(posedge clk_i or negedge rstn_i) begin
      if (!rstn_i) begin
         instr_decompressed_o       <= '0;
         instr_decompressed_ready_o <= 1'b0;
      end else begin
         instr_decompressed_ready_o <= instr_ready_i;   // one pulse per strobe
         if (instr_ready_i) begin
            instr_decompressed_o <= instr_sel;          // holds otherwise
         end
      end
   end

endmodule

`default_nettype wire

// File: rvc_decompressor_top.sv
`default_nettype none
`timescale 1ns/1ns

module rvc_decompressor_top import rv32_isa_pkg::*; (
   input  logic                  clk_i,
   input  logic                  rstn_i,
   input  logic                  instr_ready_i,
   input  logic                  is_compressed_i,
   input  logic [XLEN_INSTR-1:0] instr_i,
   output logic [XLEN_INSTR-1:0] instr_decompressed_o,
   output logic                  instr_decompressed_ready_o
);

   logic [15:0] c_word;   // compressed half of the input

   assign c_word = instr_i[15:0];

   rvc_expand_if expand_if ();

   rvc_expand_q0 rvc_expand_q0_inst (
      .rvc_word_i (c_word),
      .exp        (expand_if.exp_q0)
   );

   rvc_expand_q1 rvc_expand_q1_inst (
      .rvc_word_i (c_word),
      .exp        (expand_if.exp_q1)
   );

   rvc_expand_q2 rvc_expand_q2_inst (
      .rvc_word_i (c_word),
      .exp        (expand_if.exp_q2)
   );

   rvc_output_stage rvc_output_stage_inst (
      .clk_i                      (clk_i),
      .rstn_i                     (rstn_i),
      .instr_ready_i              (instr_ready_i),
      .is_compressed_i            (is_compressed_i),
      .quadrant_i                 (c_word[1:0]),
      .instr_i                    (instr_i),
      .exp                        (expand_if.sel),
      .instr_decompressed_o       (instr_decompressed_o),
      .instr_decompressed_ready_o (instr_decompressed_ready_o)
   );

endmodule

`default_nettype wire

// File: rvc_decompressor_props.sv
`default_nettype none
`timescale 1ns/1ns

module rvc_decompressor_props import rv32_isa_pkg::*; import rvc_pkg::*; (
   input  logic        clk_i,
   input  logic        rstn_i,
   input  logic        instr_ready_i,
   input  logic        is_compressed_i,
   input  rv32_instr_t instr_i,
   input  rv32_instr_t instr_decompressed_o,
   input  logic        instr_decompressed_ready_o
);

   c_quadrant_t quadrant;
   int unsigned assert_fails = 0;   // failed assertions so far

   assign quadrant = instr_i[1:0];

   strobe_gives_ready_a : assert property (@(posedge clk_i) disable iff (!rstn_i)
      instr_ready_i |=> instr_decompressed_ready_o)
      else begin
         $error("no ready pulse one cycle after a strobe");
         assert_fails++;
      end

   ready_needs_strobe_a : assert property (@(posedge clk_i) disable iff (!rstn_i)
      instr_decompressed_ready_o |-> $past(instr_ready_i))
      else begin
         $error("ready pulse without a strobe in the previous cycle");
         assert_fails++;
      end

   // full-width words pass through untouched
   pass_through_a : assert property (@(posedge clk_i) disable iff (!rstn_i)
      (instr_ready_i && !is_compressed_i) |=> (instr_decompressed_o == $past(instr_i)))
      else begin
         $error("uncompressed word changed on its way through");
         assert_fails++;
      end

   zero_addi4spn_a : assert property (@(posedge clk_i) disable iff (!rstn_i)
      (instr_ready_i && is_compressed_i && quadrant == Q0 && instr_i[15:5] == '0)
      |=> (instr_decompressed_o == RVC_ILLEGAL_EXP))
      else begin
         $error("addi4spn with zero immediate did not expand to the illegal word");
         assert_fails++;
      end

endmodule

bind rvc_decompressor_top rvc_decompressor_props rvc_decompressor_props_inst (
   .clk_i                      (clk_i),
   .rstn_i                     (rstn_i),
   .instr_ready_i              (instr_ready_i),
   .is_compressed_i            (is_compressed_i),
   .instr_i                    (instr_i),
   .instr_decompressed_o       (instr_decompressed_o),
   .instr_decompressed_ready_o (instr_decompressed_ready_o)
);

`default_nettype wire

// File: tb_rvc_decompressor.sv
`default_nettype none
`timescale 1ns/1ns

module tb_rvc_decompressor import rv32_isa_pkg::*; ();

   localparam int MAX_TESTS      = 64;
   localparam int TIMEOUT_CYCLES = 20;

   logic        clk_i;
   logic        rstn_i;
   logic        instr_ready_i;
   logic        is_compressed_i;
   rv32_instr_t instr_i;
   rv32_instr_t instr_decompressed_o;
   logic        instr_decompressed_ready_o;

   // four words per test: tag, is_compressed, instr_i, expected
   logic [31:0] golden_mem [0:4*MAX_TESTS-1];

   int n_tests;
   int n_failed;
   int n_errors;
   bit timed_out;
   bit test_ok;

   always #2 clk_i = ~clk_i;

   rvc_decompressor_top rvc_decompressor_top_inst (
      .clk_i                      (clk_i),
      .rstn_i                     (rstn_i),
      .instr_ready_i              (instr_ready_i),
      .is_compressed_i            (is_compressed_i),
      .instr_i                    (instr_i),
      .instr_decompressed_o       (instr_decompressed_o),
      .instr_decompressed_ready_o (instr_decompressed_ready_o)
   );

   ////////////////////
   // checks
   ////////////////////
   task automatic check_instr(input rv32_instr_t got, input rv32_instr_t expected,
                              input int test_num);
      if (got !== expected) begin
         $display("ERR instr_decompressed_o = %h, expected %h (test %0d)",
                  got, expected, test_num);
         n_errors++;
         test_ok = 1'b0;
      end
   endtask

   task automatic check_ready_pulse(input logic got, input logic expected, input int test_num);
      if (got !== expected) begin
         $display("ERR instr_decompressed_ready_o = %h, expected %h (test %0d)",
                  got, expected, test_num);
         n_errors++;
         test_ok = 1'b0;
      end
   endtask

   task automatic wait_for_ready(output bit seen, output int cycles);
      seen   = 1'b0;
      cycles = 0;
      while (!seen && cycles < TIMEOUT_CYCLES) begin
         @(negedge clk_i);
         if (instr_decompressed_ready_o === 1'b1) begin
            seen = 1'b1;
         end
         cycles++;
      end
   endtask

   task automatic log_test(input int idx, input bit ok);
      n_tests++;
      if (!ok) begin
         n_failed++;
      end
      $display("test %0d tag %0d in %h out %h: %s", idx, golden_mem[4*idx],
               golden_mem[4*idx+2], instr_decompressed_o, ok ? "ok" : "bad");
   endtask

   ////////////////////
   // stimulus
   ////////////////////
   task automatic drive_strobe(input logic compressed, input rv32_instr_t word);
      @(posedge clk_i);
      instr_ready_i   <= 1'b1;
      is_compressed_i <= compressed;
      instr_i         <= word;
   endtask

   task automatic drive_idle();
      @(posedge clk_i);
      instr_ready_i   <= 1'b0;
      is_compressed_i <= 1'b0;
      instr_i         <= '0;   // output must not follow this
   endtask

   task automatic run_single(input int idx);
      bit seen;
      int latency;
      test_ok = 1'b1;
      drive_strobe(golden_mem[4*idx+1][0], golden_mem[4*idx+2]);
      drive_idle();
      wait_for_ready(seen, latency);
      if (!seen) begin
         $display("timeout: no ready pulse within %0d cycles in test %0d", TIMEOUT_CYCLES, idx);
         timed_out = 1'b1;
         n_errors++;
         test_ok = 1'b0;
      end else begin
         if (latency != 1) begin
            $display("ready pulse came %0d cycles after the strobe in test %0d, expected 1",
                     latency, idx);
            n_errors++;
            test_ok = 1'b0;
         end
         check_instr(instr_decompressed_o, golden_mem[4*idx+3], idx);
         @(negedge clk_i);
         check_ready_pulse(instr_decompressed_ready_o, 1'b0, idx);   // one cycle wide
         check_instr(instr_decompressed_o, golden_mem[4*idx+3], idx);   // held
      end
      log_test(idx, test_ok);
   endtask

   // back-to-back strobes, pulses checked on consecutive cycles
   task automatic run_burst(input int idx_q[$]);
      bit seen;
      int latency;
      int k;
      int j;
      fork
         begin
            for (k = 0; k < idx_q.size(); k++) begin
               drive_strobe(golden_mem[4*idx_q[k]+1][0], golden_mem[4*idx_q[k]+2]);
            end
            drive_idle();
         end
         begin
            wait_for_ready(seen, latency);
            if (!seen) begin
               $display("timeout: no ready pulse within %0d cycles of the first burst strobe",
                        TIMEOUT_CYCLES);
               timed_out = 1'b1;
               n_errors++;
            end else begin
               // first strobe is sampled one edge after the burst starts
               if (latency != 2) begin
                  $display("first burst pulse came %0d cycles after its strobe, expected 1",
                           latency - 1);
                  n_errors++;
               end
               for (j = 0; j < idx_q.size(); j++) begin
                  test_ok = 1'b1;
                  check_ready_pulse(instr_decompressed_ready_o, 1'b1, idx_q[j]);
                  check_instr(instr_decompressed_o, golden_mem[4*idx_q[j]+3], idx_q[j]);
                  log_test(idx_q[j], test_ok);
                  @(negedge clk_i);
               end
               check_ready_pulse(instr_decompressed_ready_o, 1'b0, idx_q[idx_q.size()-1]);
            end
         end
      join
   endtask

   ////////////////////
   // main sequence
   ////////////////////
   initial begin
      int total;
      int idx;
      int burst_q[$];
      clk_i           = 1'b0;
      rstn_i          = 1'b0;
      instr_ready_i   = 1'b0;
      is_compressed_i = 1'b0;
      instr_i         = '0;
      n_tests         = 0;
      n_failed        = 0;
      n_errors        = 0;
      timed_out       = 1'b0;
      $readmemh("rvc_golden.hex", golden_mem);
      total = 0;
      while (total < MAX_TESTS && !$isunknown(golden_mem[4*total])) begin
         total++;
      end
      if (total == 0) begin
         $display("no vectors were read from rvc_golden.hex");
         n_errors++;
      end

      repeat (4) @(posedge clk_i);
      rstn_i <= 1'b1;
      @(negedge clk_i);
      test_ok = 1'b1;
      check_ready_pulse(instr_decompressed_ready_o, 1'b0, -1);
      check_instr(instr_decompressed_o, '0, -1);
      n_tests++;
      if (!test_ok) begin
         n_failed++;
      end
      $display("reset state: %s", test_ok ? "ok" : "bad");

      for (idx = 0; idx < total && !timed_out; idx++) begin
         if (golden_mem[4*idx] == 32'h6) begin
            burst_q.push_back(idx);   // tag 6 runs back to back later
         end else begin
            run_single(idx);
         end
      end
      if (!timed_out && burst_q.size() > 0) begin
         run_burst(burst_q);
      end

      n_errors += rvc_decompressor_top_inst.rvc_decompressor_props_inst.assert_fails;
      $display("tests %0d, failing %0d, errors %0d", n_tests, n_failed, n_errors);
      if (n_errors == 0 && !timed_out) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: rvc_golden.hex
// columns: tag  is_compressed  instr_i  expected result
// tags: 1 pass-through, 2 quadrant 0, 3 quadrant 1, 4 quadrant 2, 5 illegal, 6 back to back
01 0 00a00093 00a00093  // addi x1, x0, 10
01 0 12345001 12345001  // low bits look compressed, flag low
02 1 00000800 01010413  // c.addi4spn x8, sp, 16
02 1 00001ffc 3fc10793  // c.addi4spn x15, sp, 1020
02 1 00004144 00452483  // c.lw x9, 4(x10)
02 1 0000c024 04942023  // c.sw x9, 64(x8)
03 1 00000001 00000013  // c.nop
03 1 0000157d fff50513  // c.addi x10, -1
03 1 00005601 fe000613  // c.li x12, -32
03 1 00007139 fc010113  // c.addi16sp -64
03 1 00006785 000017b7  // c.lui x15, 0x1
03 1 0000757d fffff537  // c.lui x10, 0xfffff
03 1 0000800d 00345413  // c.srli x8, 3
03 1 000084fd 41f4d493  // c.srai x9, 31
03 1 00009941 ff057513  // c.andi x10, -16
03 1 00008c05 40940433  // c.sub x8, x9
03 1 00008d2d 00b54533  // c.xor x10, x11
03 1 00008e55 00d66633  // c.or x12, x13
03 1 00008f7d 00f77733  // c.and x14, x15
03 1 0000bffd fffff06f  // c.j -2
03 1 0000c801 00040863  // c.beqz x8, 16
03 1 0000fcf5 fe049ee3  // c.bnez x9, -4
04 1 00000512 00451513  // c.slli x10, 4
04 1 000040b2 00c12083  // c.lwsp x1, 12(sp)
04 1 0000c186 0c112023  // c.swsp x1, 192(sp)
04 1 00008082 00008067  // c.jr x1
04 1 00009282 000280e7  // c.jalr x5
04 1 0000852e 00b00533  // c.mv x10, x11
04 1 0000952e 00b50533  // c.add x10, x11
05 1 00006108 00000000  // c.ld, rv64 only
05 1 0000e022 00000000  // c.sdsp, rv64 only
05 1 00009c21 00000000  // c.addw, rv64 only
05 1 00000000 00000000  // c.addi4spn with zero immediate
06 0 00a00093 00a00093  // addi x1, x0, 10
06 1 abcd4144 00452483  // c.lw x9, 4(x10), upper half ignored
06 1 00008082 00008067  // c.jr x1
06 0 12345678 12345678  // full word
06 1 0000c60c 00b62423  // c.sw x11, 8(x12)
06 1 00006108 00000000  // c.ld, illegal

// File: rvc_decompressor.f
rv32_isa_pkg.sv
rvc_pkg.sv
rvc_expand_if.sv
rvc_expand_q0.sv
rvc_expand_q1.sv
rvc_expand_q2.sv
rvc_output_stage.sv
rvc_decompressor_top.sv
rvc_decompressor_props.sv
tb_rvc_decompressor.sv

// File: Bender.yml
package:
  name: rvc_decompressor

sources:
  - files:
      - rv32_isa_pkg.sv
      - rvc_pkg.sv
      - rvc_expand_if.sv
      - rvc_expand_q0.sv
      - rvc_expand_q1.sv
      - rvc_expand_q2.sv
      - rvc_output_stage.sv
      - rvc_decompressor_top.sv
  - target: test
    files:
      - rvc_decompressor_props.sv
      - tb_rvc_decompressor.sv
